//--- source/nano_pkg.sv
// Shared types of the core; fixed 32-bit words, 16 registers, one instruction format only
`default_nettype none

package nano_pkg;

   //////////////////////////////
   // Widths
   //////////////////////////////

   localparam int DW       = 32;             // Data word
   localparam int AW       = 32;             // Byte address
   localparam int IW       = 32;             // Instruction word
   localparam int REG_AW   = 4;              // Register index
   localparam int NUM_REGS = 1 << REG_AW;    // r0..r15
   localparam int IMM_W    = 16;             // Raw immediate field

   typedef logic [DW-1:0]     data_t;
   typedef logic [AW-1:0]     addr_t;
   typedef logic [IW-1:0]     insn_t;
   typedef logic [REG_AW-1:0] reg_addr_t;

   // Opcode values, anything above BEZ decodes as NOP
   typedef enum logic [3:0] {
      NOP  = 4'd0,
      ADD  = 4'd1,
      SUB  = 4'd2,
      AND  = 4'd3,
      OR   = 4'd4,
      XOR  = 4'd5,
      ADDI = 4'd6,
      ST   = 4'd7,                            // mem[rs1 + imm] = rs2
      BEZ  = 4'd8                             // Branch if rs1 == 0
   } opcode_e;

   // Field view of insn_t, msb first
   typedef struct packed {
      logic [3:0]       opcode;               // Raw, may be undefined
      reg_addr_t        rd;
      reg_addr_t        rs1;
      reg_addr_t        rs2;
      logic [IMM_W-1:0] imm;                  // Signed, word offset for BEZ
   } insn_fmt_s;

   //////////////////////////////
   // Stage payloads
   //////////////////////////////

   typedef struct packed {
      insn_t insn;                            // Word as returned by ibus
      addr_t pc;                              // Its fetch address
   } fetch_s;

   typedef struct packed {
      opcode_e   opcode;                      // Already mapped to a legal op
      reg_addr_t rd;
      data_t     op_a;                        // rs1 value
      data_t     op_b;                        // rs2 value
      data_t     imm;                         // Sign-extended
      addr_t     pc;
   } exec_op_s;

   typedef struct packed {
      logic  taken;
      addr_t target;                          // Only meaningful when taken
   } redirect_s;

   typedef struct packed {
      addr_t addr;
      data_t data;
   } store_s;

endpackage

`default_nettype wire

//--- source/nano_regfile.sv
// 16 x 32-bit registers, combinational reads, write visible after the next clock edge, r0 fixed at zero
`timescale 1ns/10ps
`default_nettype none

module nano_regfile (
   input  logic                clk_i,
   input  logic                arst_n_i,
   input  nano_pkg::reg_addr_t rs1_addr_i,
   input  nano_pkg::reg_addr_t rs2_addr_i,
   output nano_pkg::data_t     rs1_data_o,
   output nano_pkg::data_t     rs2_data_o,
   input  logic                we_i,
   input  nano_pkg::reg_addr_t wr_addr_i,
   input  nano_pkg::data_t     wr_data_i
);
   import nano_pkg::*;

   data_t regs [NUM_REGS];                    // Architectural registers

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         for (int i = 0; i < NUM_REGS; i++) begin
            regs[i] <= '0;                    // All registers start at zero
         end
      end else if (we_i && (wr_addr_i != '0)) begin
         regs[wr_addr_i] <= wr_data_i;        // Writes to r0 dropped
      end
   end

   // Async read ports, r0 hardwired
   assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];
   assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];

endmodule

`default_nettype wire

//--- source/nano_ifu.sv
// Fetch unit; one ibus request outstanding, next fetch waits for retirement, RESET_PC must be word aligned
`timescale 1ns/10ps
`default_nettype none

module nano_ifu #(
   parameter nano_pkg::addr_t RESET_PC = 32'h0000_0000
) (
   input  logic                clk_i,
   input  logic                arst_n_i,
   output logic                ibus_req_o,
   output nano_pkg::addr_t     ibus_addr_o,
   input  logic                ibus_valid_i,
   input  nano_pkg::insn_t     ibus_rdata_i,
   output logic                fetch_valid_o,
   output nano_pkg::fetch_s    fetch_o,
   input  logic                retire_i,
   input  nano_pkg::redirect_s redirect_i
);
   import nano_pkg::*;

   typedef enum logic [1:0] {
      START,                                  // First cycle out of reset
      WAIT_INSN,                              // Request issued, word pending
      WAIT_RETIRE                             // Word handed to decode
   } ifu_state_e;

   ifu_state_e state_q;
   addr_t      pc_q;                          // Address of current fetch
   logic       req_q;                         // One-cycle request strobe

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state_q <= START;
         pc_q    <= RESET_PC;
         req_q   <= 1'b0;
      end else begin
         req_q <= 1'b0;                       // Strobe by default
         case (state_q)
            START: begin
               req_q   <= 1'b1;               // Fetch from RESET_PC
               state_q <= WAIT_INSN;
            end
            WAIT_INSN: begin
               if (ibus_valid_i) begin
                  state_q <= WAIT_RETIRE;     // Word forwarded this cycle
               end
            end
            WAIT_RETIRE: begin
               if (retire_i) begin
                  pc_q    <= redirect_i.taken ? redirect_i.target : pc_q + addr_t'(4);
                  req_q   <= 1'b1;            // Next fetch one cycle after retire
                  state_q <= WAIT_INSN;
               end
            end
            default: state_q <= START;
         endcase
      end
   end

   assign ibus_req_o    = req_q;
   assign ibus_addr_o   = pc_q;               // Stable until the next retire
   // Stray valids outside WAIT_INSN are dropped
   assign fetch_valid_o = ibus_valid_i && (state_q == WAIT_INSN);
   assign fetch_o.insn  = ibus_rdata_i;       // Passed straight through
   assign fetch_o.pc    = pc_q;

endmodule

`default_nettype wire

//--- source/nano_idu.sv
// Decode unit; holds one instruction per fetch strobe, undefined opcodes become NOP, no hazard checks
`timescale 1ns/10ps
`default_nettype none

module nano_idu (
   input  logic                 clk_i,
   input  logic                 arst_n_i,
   input  logic                 fetch_valid_i,
   input  nano_pkg::fetch_s     fetch_i,
   output nano_pkg::reg_addr_t  rs1_addr_o,
   output nano_pkg::reg_addr_t  rs2_addr_o,
   input  nano_pkg::data_t      rs1_data_i,
   input  nano_pkg::data_t      rs2_data_i,
   output logic                 exec_valid_o,
   output nano_pkg::exec_op_s   exec_op_o
);
   import nano_pkg::*;

   insn_fmt_s insn;                           // Field view of the fetched word
   opcode_e   opcode;                         // Legalized opcode
   data_t     imm_sext;

   assign insn = fetch_i.insn;

   //////////////////////////////
   // Field decode
   //////////////////////////////

   always_comb begin
      case (insn.opcode)
         ADD, SUB, AND, OR, XOR, ADDI, ST, BEZ: begin
            opcode = opcode_e'(insn.opcode);
         end
         default: begin
            opcode = NOP;                     // Undefined maps to NOP
         end
      endcase
   end

   assign imm_sext   = {{(DW-IMM_W){insn.imm[IMM_W-1]}}, insn.imm};
   assign rs1_addr_o = insn.rs1;              // Regfile reads this cycle
   assign rs2_addr_o = insn.rs2;

   //////////////////////////////
   // Decode register
   //////////////////////////////

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         exec_valid_o <= 1'b0;
      end else begin
         exec_valid_o <= fetch_valid_i;       // One cycle behind fetch
      end
   end

   always_ff @(posedge clk_i) begin
      if (fetch_valid_i) begin
         exec_op_o.opcode <= opcode;
         exec_op_o.rd     <= insn.rd;
         exec_op_o.op_a   <= rs1_data_i;      // Operands captured with the op
         exec_op_o.op_b   <= rs2_data_i;
         exec_op_o.imm    <= imm_sext;
         exec_op_o.pc     <= fetch_i.pc;
      end
   end

endmodule

`default_nettype wire

//--- source/nano_ieu.sv
// Execute unit; every result, store and redirect is registered and appears one cycle after exec_valid
`timescale 1ns/10ps
`default_nettype none

module nano_ieu (
   input  logic                 clk_i,
   input  logic                 arst_n_i,
   input  logic                 exec_valid_i,
   input  nano_pkg::exec_op_s   exec_op_i,
   output logic                 retire_o,
   output nano_pkg::redirect_s  redirect_o,
   output logic                 wb_we_o,
   output nano_pkg::reg_addr_t  wb_addr_o,
   output nano_pkg::data_t      wb_data_o,
   output logic                 dbus_we_o,
   output nano_pkg::store_s     dbus_o
);
   import nano_pkg::*;

   data_t alu_res;
   logic  is_alu;                             // Writes rd
   logic  is_store;
   logic  br_taken;                           // BEZ with rs1 == 0
   logic  taken_q;
   addr_t target_q;

   //////////////////////////////
   // ALU
   //////////////////////////////

   always_comb begin
      case (exec_op_i.opcode)
         ADD:     alu_res = exec_op_i.op_a + exec_op_i.op_b;
         SUB:     alu_res = exec_op_i.op_a - exec_op_i.op_b;
         AND:     alu_res = exec_op_i.op_a & exec_op_i.op_b;
         OR:      alu_res = exec_op_i.op_a | exec_op_i.op_b;
         XOR:     alu_res = exec_op_i.op_a ^ exec_op_i.op_b;
         ADDI:    alu_res = exec_op_i.op_a + exec_op_i.imm;
         default: alu_res = '0;               // Not written back
      endcase
   end

   assign is_alu   = exec_op_i.opcode inside {ADD, SUB, AND, OR, XOR, ADDI};
   assign is_store = (exec_op_i.opcode == ST);
   assign br_taken = (exec_op_i.opcode == BEZ) && (exec_op_i.op_a == '0);

   //////////////////////////////
   // Retire stage
   //////////////////////////////

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         retire_o  <= 1'b0;
         wb_we_o   <= 1'b0;
         dbus_we_o <= 1'b0;
         taken_q   <= 1'b0;
      end else begin
         retire_o  <= exec_valid_i;           // Every op retires, NOP too
         wb_we_o   <= exec_valid_i && is_alu;
         dbus_we_o <= exec_valid_i && is_store;
         taken_q   <= exec_valid_i && br_taken;
      end
   end

   always_ff @(posedge clk_i) begin
      if (exec_valid_i) begin
         wb_addr_o   <= exec_op_i.rd;
         wb_data_o   <= alu_res;
         dbus_o.addr <= exec_op_i.op_a + exec_op_i.imm;   // Byte address
         dbus_o.data <= exec_op_i.op_b;
         target_q    <= exec_op_i.pc + addr_t'(exec_op_i.imm << 2);  // Word offset
      end
   end

   assign redirect_o.taken  = taken_q;
   assign redirect_o.target = target_q;

endmodule

`default_nettype wire

//--- source/nano_core.sv
// Core top level; single instruction in flight, ibus and dbus are strobes with no back-pressure
`timescale 1ns/10ps
`default_nettype none

module nano_core #(
   parameter nano_pkg::addr_t RESET_PC = 32'h0000_0000   // Word aligned
) (
   input  logic              clk_i,
   input  logic              arst_n_i,
   output logic              ibus_req_o,
   output nano_pkg::addr_t   ibus_addr_o,
   input  logic              ibus_valid_i,
   input  nano_pkg::insn_t   ibus_rdata_i,
   output logic              dbus_we_o,
   output nano_pkg::store_s  dbus_o
);
   import nano_pkg::*;

   logic      fetch_valid;                    // ifu -> idu
   fetch_s    fetch;
   reg_addr_t rs1_addr;                       // idu <-> regfile
   reg_addr_t rs2_addr;
   data_t     rs1_data;
   data_t     rs2_data;
   logic      exec_valid;                     // idu -> ieu
   exec_op_s  exec_op;
   logic      retire;                         // ieu -> ifu
   redirect_s redirect;
   logic      wb_we;                          // ieu -> regfile
   reg_addr_t wb_addr;
   data_t     wb_data;

   //////////////////////////////
   // Register file
   //////////////////////////////

   nano_regfile regfile0 (
      .clk_i(clk_i), .arst_n_i(arst_n_i),
      .rs1_addr_i(rs1_addr), .rs2_addr_i(rs2_addr),
      .rs1_data_o(rs1_data), .rs2_data_o(rs2_data),
      .we_i(wb_we), .wr_addr_i(wb_addr), .wr_data_i(wb_data));

   //////////////////////////////
   // Stage 1, fetch
   //////////////////////////////

   nano_ifu #(.RESET_PC(RESET_PC)) ifu (
      .clk_i(clk_i), .arst_n_i(arst_n_i),
      .ibus_req_o(ibus_req_o), .ibus_addr_o(ibus_addr_o),
      .ibus_valid_i(ibus_valid_i), .ibus_rdata_i(ibus_rdata_i),
      .fetch_valid_o(fetch_valid), .fetch_o(fetch),
      .retire_i(retire), .redirect_i(redirect));

   //////////////////////////////
   // Stage 2, decode
   //////////////////////////////

   nano_idu idu (
      .clk_i(clk_i), .arst_n_i(arst_n_i),
      .fetch_valid_i(fetch_valid), .fetch_i(fetch),
      .rs1_addr_o(rs1_addr), .rs2_addr_o(rs2_addr),
      .rs1_data_i(rs1_data), .rs2_data_i(rs2_data),
      .exec_valid_o(exec_valid), .exec_op_o(exec_op));

   //////////////////////////////
   // Stage 3, execute and store
   //////////////////////////////

   nano_ieu ieu (
      .clk_i(clk_i), .arst_n_i(arst_n_i),
      .exec_valid_i(exec_valid), .exec_op_i(exec_op),
      .retire_o(retire), .redirect_o(redirect),
      .wb_we_o(wb_we), .wb_addr_o(wb_addr), .wb_data_o(wb_data),
      .dbus_we_o(dbus_we_o), .dbus_o(dbus_o));

endmodule

`default_nettype wire

//--- verification/nano_core_tb.sv
// Directed tests of nano_core; programs must fit below byte 0x400, ibus answers 0 to 3 cycles late
`timescale 1ns/10ps
`default_nettype none

module nano_core_tb;
   import nano_pkg::*;

   localparam addr_t TB_RESET_PC = 32'h100;
   localparam int    TIMEOUT     = 200;                 // Cycles allowed per wait
   localparam int    MEM_WORDS   = 256;

   logic   clk = 1'b0;
   logic   arst_n;
   logic   ibus_req;
   addr_t  ibus_addr;
   logic   ibus_valid;
   insn_t  ibus_rdata;
   logic   dbus_we;
   store_s dbus;

   insn_t  imem [MEM_WORDS];                            // Word addressed
   insn_t  prog [$];                                    // Program of the current test
   addr_t  exp_pc_q [$];                                // Predicted fetch addresses
   store_s exp_st_q [$];                                // Predicted stores, in order
   int     due_q [$];                                   // Cycle each store is due

   always #2 clk = ~clk;                                // 4 ns period

   nano_core #(.RESET_PC(TB_RESET_PC)) uut (
      .clk_i(clk), .arst_n_i(arst_n),
      .ibus_req_o(ibus_req), .ibus_addr_o(ibus_addr),
      .ibus_valid_i(ibus_valid), .ibus_rdata_i(ibus_rdata),
      .dbus_we_o(dbus_we), .dbus_o(dbus));

   //////////////////////////////
   // Reporting
   //////////////////////////////

   task automatic abort_run();
      $display("sim failed");
      $fatal(1);
   endtask

   task automatic fail_run(input string why);
      $display("%s at %0t ns", why, $time);
      abort_run();
   endtask

   task automatic value_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
      $display("FAIL %0t ns %s got %h expected %h", $time, name, got, exp);
      abort_run();
   endtask

   //////////////////////////////
   // Program and reference model
   //////////////////////////////

   function automatic insn_t encode_insn(input logic [3:0] op, input logic [3:0] rd,
                                         input logic [3:0] rs1, input logic [3:0] rs2,
                                         input logic [15:0] imm);
      return {op, rd, rs1, rs2, imm};
   endfunction

   task automatic load_program();
      int base;
      base = int'(TB_RESET_PC >> 2);
      for (int i = 0; i < MEM_WORDS; i++) begin
         imem[8'(i)] = 32'hf000_0000 | 32'(i);          // Undefined op tagged with index
      end
      for (int i = 0; i < prog.size(); i++) begin
         imem[8'(base + i)] = prog[i];
      end
      prog.delete();
   endtask

   // Steps n instructions from reset and records every fetch address and store
   task automatic predict(input int n_insns);
      data_t  regs [16];
      addr_t  pc;
      insn_t  insn;
      data_t  a;
      data_t  b;
      data_t  imm;
      data_t  res;
      logic   wr;
      store_s st;
      regs = '{default: '0};                            // r0 never written
      exp_pc_q.delete();
      exp_st_q.delete();
      pc = TB_RESET_PC;
      for (int n = 0; n < n_insns; n++) begin
         exp_pc_q.push_back(pc);
         insn = imem[pc[9:2]];
         a    = regs[insn[23:20]];
         b    = regs[insn[19:16]];
         imm  = {{16{insn[15]}}, insn[15:0]};
         wr   = 1'b1;
         res  = '0;
         case (insn[31:28])
            4'd1:    res = a + b;
            4'd2:    res = a - b;
            4'd3:    res = a & b;
            4'd4:    res = a | b;
            4'd5:    res = a ^ b;
            4'd6:    res = a + imm;
            default: wr = 1'b0;                         // ST, BEZ, NOP, undefined
         endcase
         if (wr && insn[27:24] != 4'd0) begin
            regs[insn[27:24]] = res;
         end
         if (insn[31:28] == 4'd7) begin
            st.addr = a + imm;
            st.data = b;
            exp_st_q.push_back(st);
         end
         if (insn[31:28] == 4'd8 && a == '0) begin
            pc = pc + (imm << 2);                       // Taken BEZ jumps by words
         end else begin
            pc = pc + 32'd4;
         end
      end
      exp_pc_q.push_back(pc);                           // Fetch after the last one
   endtask

   //////////////////////////////
   // Bus driving and checking
   //////////////////////////////

   task automatic apply_reset();
      arst_n     = 1'b0;
      ibus_valid = 1'b0;
      ibus_rdata = '0;
      repeat (8) begin
         @(negedge clk);
         assert (!ibus_req && !dbus_we) else fail_run("Strobe active during reset");
      end
      arst_n = 1'b1;                                    // Released on a falling edge
      @(negedge clk);
      assert (ibus_req) else fail_run("No ibus request one cycle after reset");
      assert (!dbus_we) else fail_run("Store strobe right after reset");
   endtask

   task automatic run_program(input int n_insns);
      addr_t req_addr;
      logic  pending;
      logic  done;
      int    delay;
      int    cyc;
      int    idle;
      int    req_due;
      load_program();
      predict(n_insns);
      due_q.delete();
      apply_reset();
      req_addr = '0;
      pending  = 1'b0;
      done     = 1'b0;
      delay    = 0;
      cyc      = 0;
      idle     = 0;
      req_due  = -1;                                    // No word handed out yet
      while (!done) begin
         ibus_valid = 1'b0;                             // One-cycle strobe
         if (dbus_we) begin
            assert (exp_st_q.size() > 0 && due_q.size() > 0)
               else fail_run("Store strobe with no store expected");
            assert (cyc == due_q[0])
               else fail_run("Store not two cycles after its instruction word");
            assert (dbus.addr == exp_st_q[0].addr)
               else value_mismatch("dbus_o.addr", dbus.addr, exp_st_q[0].addr);
            assert (dbus.data == exp_st_q[0].data)
               else value_mismatch("dbus_o.data", dbus.data, exp_st_q[0].data);
            void'(exp_st_q.pop_front());
            void'(due_q.pop_front());
         end
         if (ibus_req) begin
            assert (!pending) else fail_run("Second ibus request while one is outstanding");
            assert (req_due < 0 || cyc == req_due)
               else fail_run("Next ibus request not three cycles after its instruction word");
            assert (ibus_addr == exp_pc_q[0])
               else value_mismatch("ibus_addr_o", ibus_addr, exp_pc_q[0]);
            void'(exp_pc_q.pop_front());
            req_addr = ibus_addr;
            idle     = 0;
            if (exp_pc_q.size() == 0) begin
               done = 1'b1;                             // Last instruction retired
            end else begin
               pending = 1'b1;
               delay   = int'($urandom_range(3, 0));
            end
         end else if (pending) begin
            delay = delay - 1;
         end
         if (pending && delay == 0) begin
            ibus_valid = 1'b1;
            ibus_rdata = imem[req_addr[9:2]];
            pending    = 1'b0;
            req_due    = cyc + 3;                       // Retire, then the next request
            if (ibus_rdata[31:28] == 4'd7) begin
               due_q.push_back(cyc + 2);                // ST word reaches dbus
            end
         end
         if (!done) begin
            @(negedge clk);
            cyc  = cyc + 1;
            idle = idle + 1;
            assert (idle <= TIMEOUT) else fail_run("Timed out waiting for an ibus request");
         end
      end
      assert (exp_st_q.size() == 0) else fail_run("Expected store never appeared");
   endtask

   //////////////////////////////
   // Tests
   //////////////////////////////

   task automatic test_alu();
      prog.push_back(encode_insn(ADDI, 4'd1, 4'd0, 4'd0, 16'h1234));
      prog.push_back(encode_insn(ADDI, 4'd2, 4'd0, 4'd0, 16'hfff9));   // -7
      prog.push_back(encode_insn(ADD,  4'd3, 4'd1, 4'd2, 16'h0));
      prog.push_back(encode_insn(SUB,  4'd4, 4'd1, 4'd2, 16'h0));
      prog.push_back(encode_insn(AND,  4'd5, 4'd1, 4'd2, 16'h0));
      prog.push_back(encode_insn(OR,   4'd6, 4'd1, 4'd2, 16'h0));
      prog.push_back(encode_insn(XOR,  4'd7, 4'd1, 4'd2, 16'h0));
      prog.push_back(encode_insn(ADDI, 4'd8, 4'd0, 4'd0, 16'h0040));   // Store base
      prog.push_back(encode_insn(ST,   4'd0, 4'd8, 4'd3, 16'h0000));
      prog.push_back(encode_insn(ST,   4'd0, 4'd8, 4'd4, 16'h0004));
      prog.push_back(encode_insn(ST,   4'd0, 4'd8, 4'd5, 16'h0008));
      prog.push_back(encode_insn(ST,   4'd0, 4'd8, 4'd6, 16'h000c));
      prog.push_back(encode_insn(ST,   4'd0, 4'd8, 4'd7, 16'h0010));
      prog.push_back(encode_insn(ADDI, 4'd0, 4'd1, 4'd0, 16'h0005));   // Write to r0
      prog.push_back(encode_insn(ST,   4'd0, 4'd8, 4'd0, 16'h0014));
      run_program(15);
   endtask

   task automatic test_store_timing();
      prog.push_back(encode_insn(ADDI, 4'd1, 4'd0, 4'd0, 16'h0200));
      prog.push_back(encode_insn(ADDI, 4'd2, 4'd0, 4'd0, 16'h1111));
      prog.push_back(encode_insn(ST,   4'd0, 4'd1, 4'd2, 16'h0000));
      prog.push_back(encode_insn(ST,   4'd0, 4'd1, 4'd1, 16'h0004));
      prog.push_back(encode_insn(ST,   4'd0, 4'd1, 4'd2, 16'hfffc));   // Negative offset
      prog.push_back(encode_insn(ST,   4'd0, 4'd0, 4'd1, 16'h003c));
      run_program(6);
   endtask

   task automatic test_branch();
      prog.push_back(encode_insn(ADDI, 4'd1, 4'd0, 4'd0, 16'h0001));
      prog.push_back(encode_insn(ADDI, 4'd2, 4'd0, 4'd0, 16'h0055));
      prog.push_back(encode_insn(BEZ,  4'd0, 4'd0, 4'd0, 16'h0002));   // Taken
      prog.push_back(encode_insn(ST,   4'd0, 4'd0, 4'd2, 16'h0080));   // Skipped
      prog.push_back(encode_insn(BEZ,  4'd0, 4'd1, 4'd0, 16'h0005));   // Not taken
      prog.push_back(encode_insn(ST,   4'd0, 4'd0, 4'd2, 16'h0084));
      run_program(5);
   endtask

   task automatic test_undefined();
      prog.push_back(encode_insn(ADDI,  4'd1, 4'd0, 4'd0, 16'h0077));
      prog.push_back(encode_insn(ADDI,  4'd2, 4'd0, 4'd0, 16'h0088));
      prog.push_back(encode_insn(4'hc,  4'd1, 4'd2, 4'd2, 16'h0000));
      prog.push_back(encode_insn(4'h9,  4'd2, 4'd0, 4'd0, 16'h0002));  // Not a BEZ
      prog.push_back(encode_insn(ST,    4'd0, 4'd0, 4'd1, 16'h0090));
      prog.push_back(encode_insn(ST,    4'd0, 4'd0, 4'd2, 16'h0094));
      run_program(6);
   endtask

   initial begin
      arst_n     = 1'b0;
      ibus_valid = 1'b0;
      ibus_rdata = '0;
      void'($urandom(32'ha328_8749));                   // Fixed seed for bus latency
      test_alu();
      test_store_timing();
      test_branch();
      test_undefined();
      $display("sim passed");
      $finish;
   end

endmodule

`default_nettype wire

//--- verilog.f
source/nano_pkg.sv
source/nano_regfile.sv
source/nano_ifu.sv
source/nano_idu.sv
source/nano_ieu.sv
source/nano_core.sv
verification/nano_core_tb.sv

//--- Makefile
# Verilator simulation of nano_core

VERILATOR ?= verilator
TOP       ?= nano_core_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/10ps
PASS_MSG  ?= sim passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
